//--- verilog/cmp_pkg.sv
// Shared constants for the serial compare unit
// Only the RV32I opcodes and funct3 codes used by branches and SLT-type ops
// XLEN must stay a multiple of the slice width chosen at the top level

package cmp_pkg;

    localparam int XLEN = 32;                      // Data word width

    // Major opcodes in instr[6:0]
    localparam logic [6:0] OPC_BRANCH = 7'b1100011; // BEQ..BGEU
    localparam logic [6:0] OPC_OP     = 7'b0110011; // SLT, SLTU
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011; // SLTI, SLTIU

    // Branch funct3 in instr[14:12]
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    // Set-less-than funct3 shared by OP and OP_IMM
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;

    // Sequencer states
    typedef enum logic [1:0] {
        IDLE = 2'd0,                               // Waiting for start
        RUN  = 2'd1,                               // Stepping slices
        FLAG = 2'd2                                // Capturing the flag
    } seq_state_t;

endpackage

//--- verilog/cmp_sequencer.sv
// Control FSM that orders load, NUM_SLICES steps, capture and done
// start is a single-cycle pulse, ignored while busy
// done is a one-cycle pulse, busy covers everything up to and including done

module cmp_sequencer (
    input  logic clk,
    input  logic rst_n,
    input  logic start,   // Request pulse
    input  logic last,    // Final slice being stepped
    output logic load,    // Latch operands, clear counter
    output logic step,    // Process one slice
    output logic capture, // Register less-than flag
    output logic busy,    // Registered busy level
    output logic done     // Registered done pulse
);

    cmp_pkg::seq_state_t state;
    logic                accept;

    // A start in the done cycle is still refused, busy is high there
    assign accept  = start && !busy && (state == cmp_pkg::IDLE);

    assign load    = accept;                       // Same cycle as start
    assign step    = (state == cmp_pkg::RUN);
    assign capture = (state == cmp_pkg::FLAG);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= cmp_pkg::IDLE;
        end else begin
            case (state)
                cmp_pkg::IDLE: begin
                    if (accept) begin
                        state <= cmp_pkg::RUN;     // Operands loaded on this edge
                    end
                end
                cmp_pkg::RUN: begin
                    if (last) begin
                        state <= cmp_pkg::FLAG;    // Last slice goes in on this edge
                    end
                end
                cmp_pkg::FLAG: begin
                    state <= cmp_pkg::IDLE;        // Flag registered on this edge
                end
                default: begin
                    state <= cmp_pkg::IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            done <= 1'b0;
            busy <= 1'b0;
        end else begin
            done <= capture;                       // One cycle after the flag edge
            if (accept) begin
                busy <= 1'b1;
            end else if (done) begin
                busy <= 1'b0;                      // Drops after the done cycle
            end
        end
    end

endmodule

//--- verilog/slice_counter.sv
// Slice counter cleared on load and advanced once per step
// last is decoded from the count, NUM_SLICES must be at least 2

module slice_counter #(
    parameter int NUM_SLICES = 4
) (
    input  logic clk,
    input  logic rst_n,
    input  logic clear, // Start of a new compare
    input  logic en,    // One slice processed
    output logic last   // Count points at the final slice
);

    localparam int CNT_W = (NUM_SLICES > 1) ? $clog2(NUM_SLICES) : 1;

    logic [CNT_W-1:0] count;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else if (clear) begin
            count <= '0;                           // Clear wins over en
        end else if (en) begin
            count <= count + 1'b1;                 // Wraps after last slice
        end
    end

    assign last = (count == CNT_W'(NUM_SLICES - 1));

endmodule

//--- verilog/serial_subtractor.sv
// Serial rs1 minus rs2 with SLICE_W bits per step and the low slice first
// Done as rs1 + ~rs2 + 1, so the final carry is set when rs1 >= rs2 unsigned
// Outputs are only meaningful after the last step, they hold until next load

module serial_subtractor #(
    parameter int SLICE_W = 8
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     load,         // Latch operands
    input  logic                     step,         // Add one slice
    input  logic [cmp_pkg::XLEN-1:0] rs1,
    input  logic [cmp_pkg::XLEN-1:0] rs2,          // Expanded immediate for SLTI(U)
    output logic                     alu_carryout, // Running carry
    output logic                     a31,          // Sign of rs1
    output logic                     b31,          // Sign of rs2
    output logic                     rzcy32        // All result slices zero so far
);

    logic [cmp_pkg::XLEN-1:0] a_sr;                // rs1 shift register
    logic [cmp_pkg::XLEN-1:0] b_sr;                // ~rs2 shift register
    logic                     carry;
    logic                     zero;
    logic [SLICE_W:0]         sum;                 // Slice result plus carry out

    // Low slices of both operands plus the carry in
    assign sum = {1'b0, a_sr[SLICE_W-1:0]} + {1'b0, b_sr[SLICE_W-1:0]}
               + {{SLICE_W{1'b0}}, carry};

    // Operand shift registers and latched sign bits
    always_ff @(posedge clk) begin
        if (load) begin
            a_sr <= rs1;
            b_sr <= ~rs2;                          // Ones complement, carry adds the one
            a31  <= rs1[cmp_pkg::XLEN-1];
            b31  <= rs2[cmp_pkg::XLEN-1];
        end else if (step) begin
            a_sr <= a_sr >> SLICE_W;               // Next slice to the bottom
            b_sr <= b_sr >> SLICE_W;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            carry <= 1'b0;
            zero  <= 1'b0;
        end else if (load) begin
            carry <= 1'b1;                         // The +1 of twos complement
            zero  <= 1'b1;                         // Sticky, cleared by any nonzero slice
        end else if (step) begin
            carry <= sum[SLICE_W];
            if (sum[SLICE_W-1:0] != '0) begin
                zero <= 1'b0;
            end
        end
    end

    assign alu_carryout = carry;
    assign rzcy32       = zero;                    // Difference zero means rs1 == rs2

endmodule

//--- verilog/cond_code.sv
// Condition codes for branches and SLT-type instructions
// raluF changes only on capture, is_brcond is combinational
// Expects alu_carryout and rzcy32 from a finished rs1 - rs2

module cond_code (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        capture,      // Register the flag
    input  logic        alu_carryout, // Set when rs1 >= rs2 unsigned
    input  logic        a31,          // Sign of rs1
    input  logic        b31,          // Sign of rs2
    input  logic        rzcy32,       // Set when rs1 == rs2
    input  logic [31:0] instr,
    output logic        raluF,        // Registered less-than, used as slt_result
    output logic        is_brcond     // Branch taken
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       lt_signed;
    logic       lt_unsigned;
    logic       cmb_aluF;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];

    // Differing signs decide on their own, otherwise the carry does
    assign lt_signed   = (a31 ^ b31) ? a31 : ~alu_carryout;
    assign lt_unsigned = ~alu_carryout;

    always_comb begin
        cmb_aluF = 1'b0;                           // Anything not listed
        if (opcode == cmp_pkg::OPC_BRANCH) begin
            case (funct3)
                cmp_pkg::F3_BLT, cmp_pkg::F3_BGE:   cmb_aluF = lt_signed;
                cmp_pkg::F3_BLTU, cmp_pkg::F3_BGEU: cmb_aluF = lt_unsigned;
                default:                            cmb_aluF = 1'b0; // BEQ/BNE use rzcy32
            endcase
        end else if ((opcode == cmp_pkg::OPC_OP) || (opcode == cmp_pkg::OPC_OP_IMM)) begin
            case (funct3)
                cmp_pkg::F3_SLT:  cmb_aluF = lt_signed;   // SLT, SLTI
                cmp_pkg::F3_SLTU: cmb_aluF = lt_unsigned; // SLTU, SLTIU
                default:          cmb_aluF = 1'b0;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            raluF <= 1'b0;
        end else if (capture) begin
            raluF <= cmb_aluF;                     // Held until the next capture
        end
    end

    always_comb begin
        is_brcond = 1'b0;                          // Not a branch
        if (opcode == cmp_pkg::OPC_BRANCH) begin
            case (funct3)
                cmp_pkg::F3_BEQ:  is_brcond = rzcy32;
                cmp_pkg::F3_BNE:  is_brcond = ~rzcy32;
                cmp_pkg::F3_BLT:  is_brcond = raluF;
                cmp_pkg::F3_BGE:  is_brcond = ~raluF;
                cmp_pkg::F3_BLTU: is_brcond = raluF;
                cmp_pkg::F3_BGEU: is_brcond = ~raluF;
                default:          is_brcond = 1'b0; // Reserved funct3
            endcase
        end
    end

endmodule

//--- verilog/compare_unit_top.sv
// Multi-cycle compare and branch-condition unit
// done comes NUM_SLICES+2 cycles after an accepted start, results hold until next start
// instr and operands must stay stable from start until done

module compare_unit_top #(
    parameter int SLICE_W = 8                      // 4, 8 or 16
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     start,
    input  logic [31:0]              instr,
    input  logic [cmp_pkg::XLEN-1:0] rs1,
    input  logic [cmp_pkg::XLEN-1:0] rs2,
    output logic                     busy,
    output logic                     done,
    output logic                     slt_result,
    output logic                     is_brcond
);

    localparam int NUM_SLICES = cmp_pkg::XLEN / SLICE_W;

    logic load;
    logic step;
    logic capture;
    logic last;
    logic alu_carryout;
    logic a31;
    logic b31;
    logic rzcy32;

    cmp_sequencer u_seq (
        .clk     (clk),
        .rst_n   (rst_n),
        .start   (start),
        .last    (last),
        .load    (load),
        .step    (step),
        .capture (capture),
        .busy    (busy),
        .done    (done)
    );

    slice_counter #(.NUM_SLICES(NUM_SLICES)) u_cnt (
        .clk   (clk),
        .rst_n (rst_n),
        .clear (load),
        .en    (step),
        .last  (last)
    );

    serial_subtractor #(.SLICE_W(SLICE_W)) u_sub (
        .clk          (clk),
        .rst_n        (rst_n),
        .load         (load),
        .step         (step),
        .rs1          (rs1),
        .rs2          (rs2),
        .alu_carryout (alu_carryout),
        .a31          (a31),
        .b31          (b31),
        .rzcy32       (rzcy32)
    );

    cond_code u_cc (
        .clk          (clk),
        .rst_n        (rst_n),
        .capture      (capture),
        .alu_carryout (alu_carryout),
        .a31          (a31),
        .b31          (b31),
        .rzcy32       (rzcy32),
        .instr        (instr),
        .raluF        (slt_result),
        .is_brcond    (is_brcond)
    );

endmodule

//--- sim/compare_unit_asserts.sv
// Control checks bound to every compare_unit_top instance
// Reaches into the sequencer for its state, expects the instance name u_seq

module compare_unit_asserts (
    input logic                clk,
    input logic                rst_n,
    input logic                busy,
    input logic                done,
    input cmp_pkg::seq_state_t state
);

    // done is a single-cycle pulse
    a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
        else $error("done stayed high for more than one cycle");

    a_done_busy: assert property (@(posedge clk) disable iff (!rst_n) done |-> busy)
        else $error("done seen while busy was low");

    // Any state past IDLE counts as busy
    a_busy_state: assert property (@(posedge clk) disable iff (!rst_n)
                                   (state != cmp_pkg::IDLE) |-> busy)
        else $error("sequencer active while busy was low");

    a_reset_quiet: assert property (@(posedge clk) $rose(rst_n) |-> (!busy && !done))
        else $error("busy or done high right after reset");

endmodule

bind compare_unit_top compare_unit_asserts u_asserts (
    .clk   (clk),
    .rst_n (rst_n),
    .busy  (busy),
    .done  (done),
    .state (u_seq.state)
);

//--- sim/compare_unit_tb.sv
// Table-driven testbench for compare_unit_top with fixed cases first and LFSR cases after
// Expected values come from a plain signed/unsigned compare model
// Inputs change on the rising edge, outputs are sampled on the falling edge

module compare_unit_tb;

    localparam int SLICE_W    = 8;
    localparam int NUM_SLICES = cmp_pkg::XLEN / SLICE_W;
    localparam int N_RAND     = 30;                // LFSR entries after the fixed table
    localparam int DONE_WAIT  = 2 * (NUM_SLICES + 4); // Cycles before giving up on done

    logic        clk;
    logic        rst_n;
    logic        start;
    logic [31:0] instr;
    logic [31:0] rs1;
    logic [31:0] rs2;
    logic        busy;
    logic        done;
    logic        slt_result;
    logic        is_brcond;

    logic [31:0] t_instr[$];                       // Stimulus table
    logic [31:0] t_rs1[$];
    logic [31:0] t_rs2[$];
    logic [1:0]  t_exp[$];                         // {slt_result, is_brcond}
    logic        t_poke[$];                        // Extra start while busy
    logic [15:0] lfsr;
    int          cyc       = 0;
    int          n_entries = 0;
    int          n_ok      = 0;
    int          n_bad     = 0;

    compare_unit_top #(.SLICE_W(SLICE_W)) UUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .instr      (instr),
        .rs1        (rs1),
        .rs2        (rs2),
        .busy       (busy),
        .done       (done),
        .slt_result (slt_result),
        .is_brcond  (is_brcond)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;                         // Period 20

    always @(posedge clk) cyc <= cyc + 1;          // Edge count for latency

    function automatic logic [31:0] mk_instr(input logic [6:0] opc, input logic [2:0] f3);
        return {17'd0, f3, 5'd0, opc};
    endfunction

    function automatic logic [15:0] galois_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1); // x^16+x^14+x^13+x^11+1
    endfunction

    // Reference model with branch and SLT rules from the ISA meaning
    function automatic logic [1:0] ref_model(input logic [31:0] ins, input logic [31:0] a,
                                             input logic [31:0] b);
        logic       lt_s;
        logic       lt_u;
        logic       eq;
        logic [2:0] f3;
        logic [1:0] r;
        lt_s = $signed(a) < $signed(b);
        lt_u = a < b;
        eq   = (a == b);
        f3   = ins[14:12];
        r    = 2'b00;                              // Anything else
        if (ins[6:0] == cmp_pkg::OPC_BRANCH) begin
            case (f3)
                cmp_pkg::F3_BEQ:  r = {1'b0, eq};
                cmp_pkg::F3_BNE:  r = {1'b0, !eq};
                cmp_pkg::F3_BLT:  r = {lt_s, lt_s};
                cmp_pkg::F3_BGE:  r = {lt_s, !lt_s};
                cmp_pkg::F3_BLTU: r = {lt_u, lt_u};
                cmp_pkg::F3_BGEU: r = {lt_u, !lt_u};
                default:          r = 2'b00;
            endcase
        end else if (ins[6:0] == cmp_pkg::OPC_OP || ins[6:0] == cmp_pkg::OPC_OP_IMM) begin
            if (f3 == cmp_pkg::F3_SLT) begin
                r = {lt_s, 1'b0};
            end else if (f3 == cmp_pkg::F3_SLTU) begin
                r = {lt_u, 1'b0};
            end
        end
        return r;
    endfunction

    function automatic logic [31:0] op_by_index(input int idx);
        case (idx)
            0:       return mk_instr(cmp_pkg::OPC_BRANCH, cmp_pkg::F3_BEQ);
            1:       return mk_instr(cmp_pkg::OPC_BRANCH, cmp_pkg::F3_BNE);
            2:       return mk_instr(cmp_pkg::OPC_BRANCH, cmp_pkg::F3_BLT);
            3:       return mk_instr(cmp_pkg::OPC_BRANCH, cmp_pkg::F3_BGE);
            4:       return mk_instr(cmp_pkg::OPC_BRANCH, cmp_pkg::F3_BLTU);
            5:       return mk_instr(cmp_pkg::OPC_BRANCH, cmp_pkg::F3_BGEU);
            6:       return mk_instr(cmp_pkg::OPC_OP, cmp_pkg::F3_SLT);
            7:       return mk_instr(cmp_pkg::OPC_OP_IMM, cmp_pkg::F3_SLT);  // SLTI
            8:       return mk_instr(cmp_pkg::OPC_OP, cmp_pkg::F3_SLTU);
            default: return mk_instr(cmp_pkg::OPC_OP_IMM, cmp_pkg::F3_SLTU); // SLTIU
        endcase
    endfunction

    task take_bits(input int n, output logic [31:0] v);
        int k;
        v = '0;
        for (k = 0; k < n; k++) begin
            v    = {v[30:0], lfsr[0]};             // One LFSR step per bit
            lfsr = galois_step(lfsr);
        end
    endtask

    task add_entry(input logic [6:0] opc, input logic [2:0] f3, input logic [31:0] a,
                   input logic [31:0] b, input logic [1:0] exp, input logic poke);
        t_instr.push_back(mk_instr(opc, f3));
        t_rs1.push_back(a);
        t_rs2.push_back(b);
        t_exp.push_back(exp);
        t_poke.push_back(poke);
    endtask

    task add_random;
        logic [31:0] v;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] ins;
        take_bits(4, v);
        ins = op_by_index(int'(v[3:0]) % 10);
        take_bits(32, a);
        take_bits(32, b);
        take_bits(3, v);
        if (v[2:0] == 3'd0) begin
            b = a;                                 // Some equal pairs for BEQ/BNE/BGE
        end
        t_instr.push_back(ins);
        t_rs1.push_back(a);
        t_rs2.push_back(b);
        t_exp.push_back(ref_model(ins, a, b));
        t_poke.push_back(1'b0);
    endtask

    task run_entry(input int i);
        int   t0;
        int   waited;
        logic bad;
        bad = 1'b0;
        @(posedge clk);
        instr <= t_instr[i];
        rs1   <= t_rs1[i];
        rs2   <= t_rs2[i];
        start <= 1'b1;
        @(negedge clk);
        t0 = cyc;
        @(posedge clk);
        start <= 1'b0;
        if (t_poke[i]) begin
            repeat (2) @(posedge clk);
            start <= 1'b1;                         // Lands in RUN, must be ignored
            @(posedge clk);
            start <= 1'b0;
        end
        waited = 0;
        @(negedge clk);
        if (busy !== 1'b1) begin
            $display("ERROR t=%0t entry %0d: busy low after an accepted start", $time, i);
            bad = 1'b1;
        end
        while (!done && waited < DONE_WAIT) begin
            @(negedge clk);
            waited++;
        end
        if (!done) begin
            $display("Entry %0d: done never arrived within %0d cycles", i, DONE_WAIT);
            n_bad++;
            return;
        end
        if (cyc - t0 != NUM_SLICES + 2) begin
            $display("ERROR t=%0t entry %0d: done after %0d cycles, expected %0d",
                     $time, i, cyc - t0, NUM_SLICES + 2);
            bad = 1'b1;
        end
        if (busy !== 1'b1) begin
            $display("ERROR t=%0t entry %0d: busy low in the done cycle", $time, i);
            bad = 1'b1;
        end
        if (slt_result !== t_exp[i][1]) begin
            $display("ERROR t=%0t entry %0d: slt_result %b, expected %b",
                     $time, i, slt_result, t_exp[i][1]);
            bad = 1'b1;
        end
        if (is_brcond !== t_exp[i][0]) begin
            $display("ERROR t=%0t entry %0d: is_brcond %b, expected %b",
                     $time, i, is_brcond, t_exp[i][0]);
            bad = 1'b1;
        end
        if (t_poke[i]) begin
            repeat (NUM_SLICES + 2) begin
                @(negedge clk);
                if (done) begin
                    $display("ERROR t=%0t entry %0d: second done from an ignored start",
                             $time, i);
                    bad = 1'b1;
                end
            end
            if (slt_result !== t_exp[i][1] || is_brcond !== t_exp[i][0]) begin
                $display("ERROR t=%0t entry %0d: results changed after done", $time, i);
                bad = 1'b1;
            end
        end
        @(negedge clk);
        if (busy !== 1'b0) begin
            $display("ERROR t=%0t entry %0d: busy still high after done", $time, i);
            bad = 1'b1;
        end
        $display("Entry %0d instr=%h rs1=%h rs2=%h slt=%b br=%b %s", i, t_instr[i],
                 t_rs1[i], t_rs2[i], slt_result, is_brcond, bad ? "MISMATCH" : "ok");
        if (bad) begin
            n_bad++;
        end else begin
            n_ok++;
        end
    endtask

    initial begin
        int i;
        start <= 1'b0;
        instr <= '0;
        rs1   <= '0;
        rs2   <= '0;
        rst_n <= 1'b0;
        lfsr  = 16'd34304;
        // Equality, single-bit differences
        add_entry(cmp_pkg::OPC_BRANCH, cmp_pkg::F3_BEQ, 32'h5, 32'h5, 2'b01, 1'b0);
        add_entry(cmp_pkg::OPC_BRANCH, cmp_pkg::F3_BEQ, 32'h5, 32'h6, 2'b00, 1'b1);
        add_entry(cmp_pkg::OPC_BRANCH, cmp_pkg::F3_BEQ, 32'h8000_0000, 32'h0, 2'b00, 1'b0);
        add_entry(cmp_pkg::OPC_BRANCH, cmp_pkg::F3_BNE, 32'h1234_5678, 32'h1234_5678,
                  2'b00, 1'b0);
        add_entry(cmp_pkg::OPC_BRANCH, cmp_pkg::F3_BNE, 32'h1234_5678, 32'h1234_5679,
                  2'b01, 1'b0);
        add_entry(cmp_pkg::OPC_BRANCH, cmp_pkg::F3_BNE, 32'h0001_0000, 32'h0, 2'b01, 1'b0);
        // Signed order across the sign boundary
        add_entry(cmp_pkg::OPC_OP, cmp_pkg::F3_SLT, 32'h8000_0000, 32'h7fff_ffff, 2'b10, 1'b0);
        add_entry(cmp_pkg::OPC_OP_IMM, cmp_pkg::F3_SLT, 32'h7fff_ffff, 32'h8000_0000,
                  2'b00, 1'b0);
        add_entry(cmp_pkg::OPC_BRANCH, cmp_pkg::F3_BLT, 32'hffff_ffff, 32'h1, 2'b11, 1'b0);
        add_entry(cmp_pkg::OPC_BRANCH, cmp_pkg::F3_BLT, 32'h8000_0000, 32'h7fff_ffff,
                  2'b11, 1'b0);
        add_entry(cmp_pkg::OPC_BRANCH, cmp_pkg::F3_BGE, 32'hffff_ffff, 32'h1, 2'b10, 1'b1);
        add_entry(cmp_pkg::OPC_BRANCH, cmp_pkg::F3_BGE, 32'h3, 32'hffff_fffe, 2'b01, 1'b0);
        add_entry(cmp_pkg::OPC_BRANCH, cmp_pkg::F3_BGE, 32'h7, 32'h7, 2'b01, 1'b0);
        // Unsigned order on the same pairs
        add_entry(cmp_pkg::OPC_OP, cmp_pkg::F3_SLTU, 32'h8000_0000, 32'h7fff_ffff,
                  2'b00, 1'b0);
        add_entry(cmp_pkg::OPC_OP_IMM, cmp_pkg::F3_SLTU, 32'h7fff_ffff, 32'h8000_0000,
                  2'b10, 1'b0);
        add_entry(cmp_pkg::OPC_BRANCH, cmp_pkg::F3_BLTU, 32'hffff_ffff, 32'h1, 2'b00, 1'b0);
        add_entry(cmp_pkg::OPC_BRANCH, cmp_pkg::F3_BGEU, 32'hffff_ffff, 32'h1, 2'b01, 1'b0);
        add_entry(cmp_pkg::OPC_BRANCH, cmp_pkg::F3_BGEU, 32'h3, 32'hffff_fffe, 2'b10, 1'b1);
        add_entry(cmp_pkg::OPC_BRANCH, cmp_pkg::F3_BLTU, 32'h7, 32'h7, 2'b00, 1'b0);
        // Neither branch nor SLT type
        add_entry(cmp_pkg::OPC_OP, 3'b000, 32'h1, 32'h2, 2'b00, 1'b0);
        add_entry(cmp_pkg::OPC_OP_IMM, 3'b100, 32'h8000_0000, 32'h1, 2'b00, 1'b0);
        add_entry(7'b0000011, cmp_pkg::F3_SLT, 32'h1, 32'h2, 2'b00, 1'b0);
        add_entry(cmp_pkg::OPC_BRANCH, 3'b010, 32'h0, 32'h1, 2'b00, 1'b0);
        repeat (N_RAND) add_random();
        n_entries = t_instr.size();
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        for (i = 0; i < n_entries; i++) begin
            run_entry(i);
        end
        $display("Summary: %0d entries, %0d ok, %0d with errors", n_entries, n_ok, n_bad);
        if (n_bad == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    initial begin
        wait (n_entries > 0);
        // Entries plus room for the poke entries and reset
        #((n_entries + n_entries / 4 + 10) * (NUM_SLICES + 4) * 20);
        $display("Watchdog expired, the run did not finish in time");
        $display("test failed");
        $finish;
    end

endmodule

//--- tb.f
verilog/cmp_pkg.sv
verilog/cmp_sequencer.sv
verilog/slice_counter.sv
verilog/serial_subtractor.sv
verilog/cond_code.sv
verilog/compare_unit_top.sv
sim/compare_unit_asserts.sv
sim/compare_unit_tb.sv

//--- Makefile
# Verilator build and run for the compare unit testbench

SIM := obj_dir/Vcompare_unit_tb

.PHONY: all run clean

all: run

$(SIM): tb.f $(shell cat tb.f)
	verilator --binary --timing --assert --top-module compare_unit_tb -f tb.f

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "test passed"

clean:
	rm -rf obj_dir
